// File: fill_queue.sv
// Fill-job FIFO between the refill sequencer and the fill writer.
// Lets the next miss go to memory while an earlier fill waits on the L2.
// Head is valid one cycle after a push into an empty queue; order is kept.

`timescale 1ns/1ps

module fill_queue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  mem_ctrl_pkg::fill_job_t job_in,
    output logic                    full,
    output logic                    valid,
    output mem_ctrl_pkg::fill_job_t job_out,
    input  logic                    pop
);
    import mem_ctrl_pkg::*;

    fill_job_t             entries [FILL_DEPTH];
    logic [FILL_PTR_W-1:0] wr_ptr;
    logic [FILL_PTR_W-1:0] rd_ptr;
    logic [FILL_CNT_W-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    function automatic logic [FILL_PTR_W-1:0] next_ptr(input logic [FILL_PTR_W-1:0] ptr);
        logic [FILL_PTR_W-1:0] nxt;
        if (ptr == FILL_PTR_W'(FILL_DEPTH - 1)) begin
            nxt = '0;                         // wrap
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign full    = (count == FILL_CNT_W'(FILL_DEPTH));
    assign valid   = (count != '0);
    assign do_push = push && !full;
    assign do_pop  = pop && valid;
    assign job_out = entries[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // idle or push with pop
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= job_in;
        end
    end

endmodule

// File: fill_writer.sv
// Fill writer of the miss handler.
// Takes the head fill job, writes the refill line into the chosen L2 way and
// holds the write until the L2 answers with l2_complete_w. The next cycle it
// pops the queue, pulses fill_done and, for a read miss, writes the addressed
// 128-bit word into the instruction or data L1.

`timescale 1ns/1ps

module fill_writer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid,
    input  mem_ctrl_pkg::fill_job_t job,
    output logic                    pop,
    input  logic                    l2_complete_w,
    output mem_ctrl_pkg::l2_fill_t  l2_fill,
    output mem_ctrl_pkg::l1_fill_t  l1_fill,
    output logic                    fill_done
);
    import mem_ctrl_pkg::*;

    fill_state_e        state, state_d;
    logic [L2_WAYS-1:0] way_dec;
    logic               l1_wr;
    logic [WORD_MSB-WORD_LSB:0] word_sel;

    //////////////////////////////
    // state machine
    //////////////////////////////
    always_comb begin
        state_d = state;
        case (state)
            FILL_IDLE: if (valid) state_d = FILL_L2;
            FILL_L2:   if (l2_complete_w) state_d = FILL_L1;
            FILL_L1:   state_d = FILL_IDLE;    // one-cycle finish
            default:   state_d = FILL_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FILL_IDLE;
        end else begin
            state <= state_d;
        end
    end

    // way decode, one-hot
    always_comb begin
        way_dec = '0;
        for (int w = 0; w < L2_WAYS; w++) begin
            if (job.req.l2_way == w[1:0]) way_dec[w] = 1'b1;
        end
    end

    assign pop       = (state == FILL_L1);
    assign fill_done = (state == FILL_L1);
    assign l1_wr     = (state == FILL_L1) && job.req.is_read;  // write miss skips L1
    assign word_sel  = job.req.addr[WORD_MSB:WORD_LSB];

    //////////////////////////////
    // L2 write
    //////////////////////////////
    always_comb begin
        l2_fill.way_we         = (state == FILL_L2) ? way_dec : '0;
        l2_fill.wd_from_mem_en = (state == FILL_L2);
        l2_fill.index          = job.req.addr[L2_IDX_MSB:L2_IDX_LSB];
        l2_fill.tag.valid      = 1'b1;
        l2_fill.tag.tag        = job.req.addr[ADDR_W-1:L2_TAG_LSB];
        l2_fill.data           = job.line;
    end

    // L1 forward of the requested word
    always_comb begin
        l1_fill.ic_we     = l1_wr && (job.req.target == L1_ICACHE);
        l1_fill.dc_we     = l1_wr && (job.req.target == L1_DCACHE);
        l1_fill.block_we  = '0;
        if (l1_fill.ic_we || l1_fill.dc_we) begin
            l1_fill.block_we = job.req.l1_way ? 2'b10 : 2'b01;
        end
        l1_fill.index     = job.req.addr[L1_IDX_W-1:0];
        l1_fill.tag.valid = 1'b1;
        l1_fill.tag.tag   = job.req.addr[ADDR_W-1:L1_TAG_LSB];
        l1_fill.data      = job.line[word_sel*WORD_W +: WORD_W];
    end

endmodule

// File: mem_ctrl_assert.sv
// Protocol checks for the L2 miss handler, bound into the top level.
// Covers the memory command levels, the L2 way enables and the L1 write
// enables. fail_cnt counts failures for the closing report of the testbench.

`timescale 1ns/1ps

module mem_ctrl_assert (
    input logic                   clk,
    input logic                   rst_n,
    input mem_ctrl_pkg::mem_cmd_t mem_cmd,
    input logic                   mem_complete_r,
    input mem_ctrl_pkg::l2_fill_t l2_fill,
    input mem_ctrl_pkg::l1_fill_t l1_fill
);

    int fail_cnt = 0;

    //////////////////////////////
    // memory side
    //////////////////////////////
    re_we_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_cmd.re && mem_cmd.we))
        else begin
            fail_cnt++;
            $error("memory read and write requested together");
        end

    // read level held until memory answers
    re_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_cmd.re && !mem_complete_r) |=> mem_cmd.re)
        else begin
            fail_cnt++;
            $error("mem_cmd.re dropped before mem_complete_r");
        end

    //////////////////////////////
    // cache side
    //////////////////////////////
    way_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(l2_fill.way_we))
        else begin
            fail_cnt++;
            $error("l2_fill.way_we enables more than one way");
        end

    l1_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(l1_fill.ic_we && l1_fill.dc_we))
        else begin
            fail_cnt++;
            $error("instruction and data L1 written together");
        end

endmodule

bind mem_ctrl_top mem_ctrl_assert u_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .mem_cmd        (mem_cmd),
    .mem_complete_r (mem_complete_r),
    .l2_fill        (l2_fill),
    .l1_fill        (l1_fill)
);

// File: mem_ctrl_pkg.sv
// Shared definitions for the L2 miss handler.
// Holds the address-field positions, the FSM state enums and the packed structs
// that pass between the refill sequencer, the fill queue and the fill writer.
// Import it inside a module body; port lists use mem_ctrl_pkg:: scoped names.

package mem_ctrl_pkg;

    //////////////////////////////
    // widths and address fields
    //////////////////////////////
    localparam int ADDR_W     = 28;             // block-word address
    localparam int MEM_ADDR_W = 26;             // line address, no word field
    localparam int LINE_W     = 512;
    localparam int WORD_W     = 128;

    localparam int WORD_LSB   = 0;
    localparam int WORD_MSB   = 1;
    localparam int L2_IDX_LSB = 2;
    localparam int L2_IDX_MSB = 10;
    localparam int L2_IDX_W   = L2_IDX_MSB - L2_IDX_LSB + 1;
    localparam int L2_TAG_LSB = 11;
    localparam int L2_TAG_W   = ADDR_W - L2_TAG_LSB;  // 17 bits
    localparam int L1_IDX_W   = 8;              // address bits 7:0
    localparam int L1_TAG_LSB = 8;
    localparam int L1_TAG_W   = ADDR_W - L1_TAG_LSB;  // 20 bits

    localparam int L2_WAYS    = 4;
    localparam int FILL_DEPTH = 2;
    localparam int FILL_PTR_W = (FILL_DEPTH > 1) ? $clog2(FILL_DEPTH) : 1;
    localparam int FILL_CNT_W = $clog2(FILL_DEPTH + 1);

    //////////////////////////////
    // basic types
    //////////////////////////////
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [WORD_W-1:0] word_t;

    typedef struct packed {
        logic                valid;
        logic [L2_TAG_W-1:0] tag;
    } l2_tag_t;

    typedef struct packed {
        logic                valid;
        logic [L1_TAG_W-1:0] tag;
    } l1_tag_t;

    typedef enum logic [1:0] {L1_NONE, L1_ICACHE, L1_DCACHE} l1_target_e;

    typedef enum logic [1:0] {
        SEQ_IDLE, SEQ_WRITE_MEM, SEQ_WAIT_SLOT, SEQ_READ_MEM
    } seq_state_e;

    typedef enum logic [1:0] {FILL_IDLE, FILL_L2, FILL_L1} fill_state_e;

    //////////////////////////////
    // bundles
    //////////////////////////////
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [1:0]        l2_way;      // victim / refill way
        logic              is_read;     // read miss forwards a word to L1
        l1_target_e        target;
        logic              l1_way;
    } miss_req_t;

    typedef struct packed {
        l2_tag_t [L2_WAYS-1:0] tag;
        line_t   [L2_WAYS-1:0] line;
    } victim_t;

    typedef struct packed {
        logic                  re;
        logic                  we;
        logic [MEM_ADDR_W-1:0] addr;
        line_t                 wd;
    } mem_cmd_t;

    typedef struct packed {
        miss_req_t req;
        line_t     line;                // refill data from memory
    } fill_job_t;

    typedef struct packed {
        logic [L2_WAYS-1:0]  way_we;    // one-hot
        logic                wd_from_mem_en;
        logic [L2_IDX_W-1:0] index;
        l2_tag_t             tag;
        line_t               data;
    } l2_fill_t;

    typedef struct packed {
        logic                ic_we;
        logic                dc_we;
        logic [1:0]          block_we;
        logic [L1_IDX_W-1:0] index;
        l1_tag_t             tag;
        word_t               data;
    } l1_fill_t;

endpackage

// File: mem_ctrl_top.sv
// Top level of the L2 miss handler.
// Connects the refill sequencer, the fill queue and the fill writer.
// Memory side: mem_cmd levels with completion pulses.
// Cache side: miss strobes in, L2 and L1 fill writes out.

`timescale 1ns/1ps

module mem_ctrl_top (
    input  logic                    clk,
    input  logic                    rst_n,
    // miss from L2
    input  logic                    access_mem_clean,
    input  logic                    access_mem_dirty,
    input  mem_ctrl_pkg::miss_req_t req,
    input  mem_ctrl_pkg::victim_t   victim,
    output logic                    memory_busy,
    // memory
    input  logic                    mem_complete_w,
    input  logic                    mem_complete_r,
    input  mem_ctrl_pkg::line_t     mem_rd,
    output mem_ctrl_pkg::mem_cmd_t  mem_cmd,
    // fills
    input  logic                    l2_complete_w,
    output mem_ctrl_pkg::l2_fill_t  l2_fill,
    output mem_ctrl_pkg::l1_fill_t  l1_fill,
    output logic                    fill_done
);
    import mem_ctrl_pkg::*;

    logic      push;
    logic      full;
    logic      valid;
    logic      pop;
    fill_job_t job_in;
    fill_job_t job_out;

    refill_seq u_seq (
        .clk              (clk),
        .rst_n            (rst_n),
        .access_mem_clean (access_mem_clean),
        .access_mem_dirty (access_mem_dirty),
        .req              (req),
        .victim           (victim),
        .mem_complete_w   (mem_complete_w),
        .mem_complete_r   (mem_complete_r),
        .mem_rd           (mem_rd),
        .mem_cmd          (mem_cmd),
        .memory_busy      (memory_busy),
        .full             (full),
        .push             (push),
        .job              (job_in)
    );

    fill_queue u_queue (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (push),
        .job_in  (job_in),
        .full    (full),
        .valid   (valid),
        .job_out (job_out),
        .pop     (pop)
    );

    fill_writer u_fill (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid         (valid),
        .job           (job_out),
        .pop           (pop),
        .l2_complete_w (l2_complete_w),
        .l2_fill       (l2_fill),
        .l1_fill       (l1_fill),
        .fill_done     (fill_done)
    );

endmodule

// File: refill_seq.sv
// Refill sequencer of the miss handler.
// Takes one L2 miss at a time from the clean or dirty strobe, writes a dirty
// victim back to memory, then reads the refill line and pushes it as a fill job.
// Holds memory_busy from the cycle after the strobe through the push cycle.

`timescale 1ns/1ps

module refill_seq (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    access_mem_clean,
    input  logic                    access_mem_dirty,
    input  mem_ctrl_pkg::miss_req_t req,
    input  mem_ctrl_pkg::victim_t   victim,
    input  logic                    mem_complete_w,
    input  logic                    mem_complete_r,
    input  mem_ctrl_pkg::line_t     mem_rd,
    output mem_ctrl_pkg::mem_cmd_t  mem_cmd,
    output logic                    memory_busy,
    input  logic                    full,
    output logic                    push,
    output mem_ctrl_pkg::fill_job_t job
);
    import mem_ctrl_pkg::*;

    seq_state_e            state, state_d;
    logic                  re_q, we_q;
    logic [MEM_ADDR_W-1:0] addr_q;
    line_t                 wd_q;
    miss_req_t             req_q;          // accepted miss
    line_t                 line_q;         // refill line
    miss_req_t             cur_req;
    logic                  accept;
    logic                  start_wr;
    logic                  start_rd;
    logic [MEM_ADDR_W-1:0] wr_addr;
    logic [MEM_ADDR_W-1:0] rd_addr;

    assign memory_busy = (state != SEQ_IDLE) || push;
    assign accept      = !memory_busy && (access_mem_clean || access_mem_dirty);
    assign start_wr    = accept && access_mem_dirty && !access_mem_clean;  // clean wins

    // request is live on the strobe cycle, registered afterwards
    assign cur_req = accept ? req : req_q;
    assign rd_addr = cur_req.addr[ADDR_W-1:WORD_MSB+1];
    assign wr_addr = {victim.tag[req.l2_way].tag, req.addr[L2_IDX_MSB:L2_IDX_LSB]};

    //////////////////////////////
    // next state
    //////////////////////////////
    always_comb begin
        state_d = state;
        case (state)
            SEQ_IDLE: begin
                if (start_wr) begin
                    state_d = SEQ_WRITE_MEM;
                end else if (accept) begin
                    state_d = full ? SEQ_WAIT_SLOT : SEQ_READ_MEM;
                end
            end
            SEQ_WRITE_MEM: begin
                if (mem_complete_w) begin
                    state_d = full ? SEQ_WAIT_SLOT : SEQ_READ_MEM;
                end
            end
            SEQ_WAIT_SLOT: begin
                if (!full) begin
                    state_d = SEQ_READ_MEM;   // slot freed by the fill writer
                end
            end
            SEQ_READ_MEM: begin
                if (mem_complete_r) begin
                    state_d = SEQ_IDLE;
                end
            end
            default: state_d = SEQ_IDLE;
        endcase
    end

    assign start_rd = (state_d == SEQ_READ_MEM) && (state != SEQ_READ_MEM);

    //////////////////////////////
    // control registers
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SEQ_IDLE;
            re_q  <= 1'b0;
            we_q  <= 1'b0;
            push  <= 1'b0;
        end else begin
            state <= state_d;
            push  <= (state == SEQ_READ_MEM) && mem_complete_r;
            if (start_rd) begin
                re_q <= 1'b1;
            end else if (mem_complete_r) begin
                re_q <= 1'b0;                 // level drops after the pulse
            end
            if (start_wr) begin
                we_q <= 1'b1;
            end else if (mem_complete_w) begin
                we_q <= 1'b0;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (start_wr) begin
            addr_q <= wr_addr;                // victim tag over set index
            wd_q   <= victim.line[req.l2_way];
        end else if (start_rd) begin
            addr_q <= rd_addr;
        end
        if ((state == SEQ_READ_MEM) && mem_complete_r) begin
            line_q <= mem_rd;
        end
    end

    always_comb begin
        mem_cmd.re   = re_q;
        mem_cmd.we   = we_q;
        mem_cmd.addr = addr_q;
        mem_cmd.wd   = wd_q;
        job.req      = req_q;
        job.line     = line_q;
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the miss handler testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_mem_ctrl -o tb_mem_ctrl \
    && ./obj_dir/tb_mem_ctrl +verilator+error+limit+100 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "^Finished with no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb_mem_ctrl.sv
// Testbench for the L2 miss handler.
// Models main memory and the L2 write port, sends clean and dirty misses and
// checks memory commands, L2 fills and L1 forwards with immediate assertions.
// A final phase holds off the L2 completion to stall the fill queue.

`timescale 1ns/1ps

module tb_mem_ctrl;
    import mem_ctrl_pkg::*;

    logic      clk;
    logic      rst_n;
    logic      access_mem_clean;
    logic      access_mem_dirty;
    miss_req_t req;
    victim_t   victim;
    logic      memory_busy;
    logic      mem_complete_w;
    logic      mem_complete_r;
    line_t     mem_rd;
    mem_cmd_t  mem_cmd;
    logic      l2_complete_w;
    l2_fill_t  l2_fill;
    l1_fill_t  l1_fill;
    logic      fill_done;

    mem_cmd_t  exp_mem[$];              // memory ops in issue order
    miss_req_t exp_fill[$];             // fills in request order
    mem_cmd_t  mem_write_log[$];
    int        errors = 0;
    int        reads_started = 0;
    int        fills_sent = 0;
    int        fills_done = 0;
    int        dirty_sent = 0;
    int        l1_expected = 0;
    int        l1_writes = 0;
    logic      hold_l2 = 1'b0;

    mem_ctrl_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // lane i of a line holds the line address plus i
    function automatic line_t mem_pattern(input logic [MEM_ADDR_W-1:0] addr);
        line_t line;
        for (int i = 0; i < LINE_W / 32; i++) begin
            line[i*32 +: 32] = 32'(addr) + 32'(i);
        end
        return line;
    endfunction

    task automatic check_value(input string name, input line_t exp_v, input line_t act_v);
        assert (exp_v == act_v) else begin
            errors++;
            $display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    //////////////////////////////
    // memory model
    //////////////////////////////
    initial begin : memory_model
        mem_cmd_t cmd;
        mem_cmd_t want;
        int       delay;
        forever begin
            next_cycle();
            if (rst_n && (mem_cmd.re || mem_cmd.we)) begin
                cmd = mem_cmd;
                want = cmd;
                if (exp_mem.size() == 0) begin
                    report_failure("memory command issued with no miss outstanding");
                end else begin
                    want = exp_mem.pop_front();
                end
                check_value("mem_cmd.re", line_t'(want.re), line_t'(cmd.re));
                check_value("mem_cmd.we", line_t'(want.we), line_t'(cmd.we));
                check_value("mem_cmd.addr", line_t'(want.addr), line_t'(cmd.addr));
                if (cmd.we) begin
                    check_value("mem_cmd.wd", want.wd, cmd.wd);
                    mem_write_log.push_back(cmd);
                end else begin
                    // a read may only start while the fill queue has a free slot
                    check_value("fill queue slot", line_t'(1'b1),
                                line_t'(reads_started - fills_done < FILL_DEPTH));
                    reads_started++;
                end
                delay = 1 + ($urandom % 6);
                repeat (delay - 1) next_cycle();
                mem_rd = mem_pattern(cmd.addr);
                if (cmd.we) mem_complete_w = 1'b1;
                else        mem_complete_r = 1'b1;
                next_cycle();
                mem_complete_w = 1'b0;
                mem_complete_r = 1'b0;
            end
        end
    end

    //////////////////////////////
    // L2 write port model
    //////////////////////////////
    initial begin : l2_model
        miss_req_t         want;
        logic [ADDR_W-1:0] a;
        line_t             line;
        logic              exp_ic;
        logic              exp_dc;
        logic [1:0]        exp_blk;
        int                delay;
        forever begin
            next_cycle();
            if (rst_n && l2_fill.way_we != '0) begin
                want = '0;
                if (exp_fill.size() == 0) report_failure("L2 fill with no miss outstanding");
                else                      want = exp_fill.pop_front();
                a    = want.addr;
                line = mem_pattern(a[ADDR_W-1:WORD_MSB+1]);
                check_value("l2_fill.way_we", line_t'(4'b0001 << want.l2_way),
                            line_t'(l2_fill.way_we));
                check_value("l2_fill.data", line, l2_fill.data);
                check_value("l2_fill.tag", line_t'({1'b1, a[ADDR_W-1:L2_TAG_LSB]}),
                            line_t'(l2_fill.tag));
                check_value("l2_fill.index", line_t'(a[L2_IDX_MSB:L2_IDX_LSB]),
                            line_t'(l2_fill.index));
                check_value("l2_fill.wd_from_mem_en", line_t'(1'b1),
                            line_t'(l2_fill.wd_from_mem_en));
                delay = hold_l2 ? 20 : 1 + ($urandom % 4);
                repeat (delay - 1) next_cycle();
                l2_complete_w = 1'b1;
                next_cycle();
                l2_complete_w = 1'b0;
                // writer is in its finishing cycle
                exp_ic  = want.is_read && (want.target == L1_ICACHE);
                exp_dc  = want.is_read && (want.target == L1_DCACHE);
                exp_blk = (exp_ic || exp_dc) ? (want.l1_way ? 2'b10 : 2'b01) : 2'b00;
                check_value("fill_done", line_t'(1'b1), line_t'(fill_done));
                check_value("l1_fill.ic_we", line_t'(exp_ic), line_t'(l1_fill.ic_we));
                check_value("l1_fill.dc_we", line_t'(exp_dc), line_t'(l1_fill.dc_we));
                check_value("l1_fill.block_we", line_t'(exp_blk), line_t'(l1_fill.block_we));
                if (exp_ic || exp_dc) begin
                    check_value("l1_fill.data",
                                line_t'(line[a[WORD_MSB:WORD_LSB]*WORD_W +: WORD_W]),
                                line_t'(l1_fill.data));
                    check_value("l1_fill.index", line_t'(a[L1_IDX_W-1:0]),
                                line_t'(l1_fill.index));
                    check_value("l1_fill.tag", line_t'({1'b1, a[ADDR_W-1:L1_TAG_LSB]}),
                                line_t'(l1_fill.tag));
                end
                fills_done++;
            end
        end
    end

    initial begin : l1_monitor
        forever begin
            next_cycle();
            if (l1_fill.ic_we || l1_fill.dc_we) l1_writes++;
        end
    end

    task automatic send_miss(input logic dirty);
        miss_req_t r;
        victim_t   v;
        mem_cmd_t  op;
        int        cycles;
        r.addr    = ADDR_W'($urandom);
        r.l2_way  = 2'($urandom);
        r.is_read = 1'($urandom);
        r.target  = l1_target_e'($urandom % 3);
        r.l1_way  = 1'($urandom);
        for (int w = 0; w < L2_WAYS; w++) begin
            v.tag[w] = l2_tag_t'($urandom);
            for (int k = 0; k < LINE_W / 32; k++) begin
                v.line[w][k*32 +: 32] = $urandom;
            end
        end
        cycles = 0;
        while (memory_busy && cycles < 2000) begin
            next_cycle();
            cycles++;
        end
        if (memory_busy) report_failure("memory_busy stayed high, miss not sent");
        op = '0;
        if (dirty) begin
            op.we   = 1'b1;                // victim tag over the request's set index
            op.addr = {v.tag[r.l2_way].tag, r.addr[L2_IDX_MSB:L2_IDX_LSB]};
            op.wd   = v.line[r.l2_way];
            exp_mem.push_back(op);
            dirty_sent++;
        end
        op      = '0;
        op.re   = 1'b1;
        op.addr = r.addr[ADDR_W-1:WORD_MSB+1];
        exp_mem.push_back(op);
        exp_fill.push_back(r);
        fills_sent++;
        if (r.is_read && r.target != L1_NONE) l1_expected++;
        req              = r;
        victim           = v;
        access_mem_clean = !dirty;
        access_mem_dirty = dirty;
        next_cycle();
        access_mem_clean = 1'b0;
        access_mem_dirty = 1'b0;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (fills_done != fills_sent && cycles < 2000) begin
            next_cycle();
            cycles++;
        end
        if (fills_done != fills_sent) report_failure("timed out waiting for fills to finish");
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        void'($urandom(32'hb6fb58ce));
        rst_n            = 1'b0;
        access_mem_clean = 1'b0;
        access_mem_dirty = 1'b0;
        req              = '0;
        victim           = '0;
        mem_complete_w   = 1'b0;
        mem_complete_r   = 1'b0;
        mem_rd           = '0;
        l2_complete_w    = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        next_cycle();
        // quiet outputs before the first miss
        check_value("mem_cmd.re", '0, line_t'(mem_cmd.re));
        check_value("mem_cmd.we", '0, line_t'(mem_cmd.we));
        check_value("memory_busy", '0, line_t'(memory_busy));
        check_value("l2_fill.way_we", '0, line_t'(l2_fill.way_we));
        check_value("l2_fill.wd_from_mem_en", '0, line_t'(l2_fill.wd_from_mem_en));
        check_value("l1_fill.ic_we", '0, line_t'(l1_fill.ic_we));
        check_value("l1_fill.dc_we", '0, line_t'(l1_fill.dc_we));
        check_value("l1_fill.block_we", '0, line_t'(l1_fill.block_we));
        check_value("fill_done", '0, line_t'(fill_done));

        for (int i = 0; i < 12; i++) send_miss(i % 2 == 1);  // alternating clean and dirty
        wait_drained();

        hold_l2 = 1'b1;                    // L2 stall fills the queue
        for (int i = 0; i < 3; i++) send_miss(1'b0);
        wait_drained();
        hold_l2 = 1'b0;
        next_cycle();                      // let the monitors settle

        check_value("memory writes", line_t'(dirty_sent), line_t'(mem_write_log.size()));
        check_value("L1 writes", line_t'(l1_expected), line_t'(l1_writes));
        $display("failed checks: %0d, failed assertions: %0d", errors, DUT.u_assert.fail_cnt);
        if (errors == 0 && DUT.u_assert.fail_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: verilog.f
mem_ctrl_pkg.sv
refill_seq.sv
fill_queue.sv
fill_writer.sv
mem_ctrl_top.sv
mem_ctrl_assert.sv
tb_mem_ctrl.sv
